//--- design/port_decode.sv
// port decoder: low byte to port selects, #AF index to write strobes, bus drive control
`default_nettype none

module port_decode
(
	input  wire [15:0]              a,
	input  wire                     iowr_s,
	input  wire                     iord_s,
	input  wire                     iord,
	input  wire                     dos,
	input  wire                     lock48,
	output port_map_pkg::port_sel_t sel,
	output zcfg_pkg::xt_wr_t        xt_wr,
	output zcfg_pkg::video_wr_t     video_wr,
	output zcfg_pkg::dma_wr_t       dma_wr,
	output logic                    beeper_wr,
	output logic                    covox_wr,
	output logic                    sd_cfg_wr,
	output logic                    sd_start,
	output logic                    porthit,
	output logic                    external_port,
	output logic                    dataout
);

	logic [7:0] loa;
	logic [7:0] hoa;
	logic       fe_w;    // write to fe
	logic       xt_w;    // write to #nnAF
	logic       p7ffd_w; // accepted 7ffd write

	assign loa = a[7:0];
	assign hoa = a[15:8];

	// ------------------------------------------------------------------------
	// port selects and bus control
	// ------------------------------------------------------------------------
	always_comb
	begin
		sel.fe     = (loa == port_map_pkg::PORT_FE);
		sel.fd     = (loa == port_map_pkg::PORT_FD);
		sel.xt     = (loa == port_map_pkg::PORT_XT);
		sel.covox  = (loa == port_map_pkg::PORT_COVOX);
		sel.kjoy   = (loa == port_map_pkg::PORT_KJOY);
		sel.kmouse = (loa == port_map_pkg::PORT_KMOUSE);
		sel.sdcfg  = (loa == port_map_pkg::PORT_SDCFG);
		sel.sddat  = (loa == port_map_pkg::PORT_SDDAT);
		sel.ay     = sel.fd & a[15];     // bffd/fffd
	end

	// joystick and sd card hidden while dos rom is on
	assign porthit = sel.fe | sel.xt | sel.fd | sel.covox | sel.kmouse
		| (sel.kjoy & ~dos) | ((sel.sdcfg | sel.sddat) & ~dos);

	assign external_port = sel.ay;  // sound chip drives the bus itself
	assign dataout = porthit & iord & ~external_port;

	// ------------------------------------------------------------------------
	// write strobes
	// ------------------------------------------------------------------------
	assign fe_w    = sel.fe & iowr_s;
	assign xt_w    = sel.xt & iowr_s;
	assign p7ffd_w = sel.fd & ~a[15] & iowr_s & ~lock48; // closed for good by lock48

	assign beeper_wr = fe_w;
	assign covox_wr  = sel.covox & iowr_s;

	always_comb
	begin
		xt_wr.rampage   = xt_w & (hoa[7:2] == port_map_pkg::XT_RAMPAGE[7:2]); // #10..#13
		xt_wr.fmaddr    = xt_w & (hoa == port_map_pkg::XT_FMADDR);
		xt_wr.sysconf   = xt_w & (hoa == port_map_pkg::XT_SYSCONF);
		xt_wr.memconf   = xt_w & (hoa == port_map_pkg::XT_MEMCONF);
		xt_wr.cacheconf = xt_w & (hoa == port_map_pkg::XT_CACHECONF);
		xt_wr.fddvirt   = xt_w & (hoa == port_map_pkg::XT_FDDVIRT);
		xt_wr.intmask   = xt_w & (hoa == port_map_pkg::XT_INTMASK);
		xt_wr.p7ffd     = p7ffd_w;
	end

	always_comb
	begin
		video_wr.zborder   = fe_w;        // spectrum border from fe
		video_wr.border    = xt_w & (hoa == port_map_pkg::XT_XBORDER);
		video_wr.zvpage    = p7ffd_w;     // shadow screen bit
		video_wr.vpage     = xt_w & (hoa == port_map_pkg::XT_VPAGE);
		video_wr.vconf     = xt_w & (hoa == port_map_pkg::XT_VCONF);
		video_wr.gx_offsl  = xt_w & (hoa == port_map_pkg::XT_GXOFFSL);
		video_wr.gx_offsh  = xt_w & (hoa == port_map_pkg::XT_GXOFFSH);
		video_wr.gy_offsl  = xt_w & (hoa == port_map_pkg::XT_GYOFFSL);
		video_wr.gy_offsh  = xt_w & (hoa == port_map_pkg::XT_GYOFFSH);
		video_wr.t0x_offsl = xt_w & (hoa == port_map_pkg::XT_T0XOFFSL);
		video_wr.t0x_offsh = xt_w & (hoa == port_map_pkg::XT_T0XOFFSH);
		video_wr.t0y_offsl = xt_w & (hoa == port_map_pkg::XT_T0YOFFSL);
		video_wr.t0y_offsh = xt_w & (hoa == port_map_pkg::XT_T0YOFFSH);
		video_wr.t1x_offsl = xt_w & (hoa == port_map_pkg::XT_T1XOFFSL);
		video_wr.t1x_offsh = xt_w & (hoa == port_map_pkg::XT_T1XOFFSH);
		video_wr.t1y_offsl = xt_w & (hoa == port_map_pkg::XT_T1YOFFSL);
		video_wr.t1y_offsh = xt_w & (hoa == port_map_pkg::XT_T1YOFFSH);
		video_wr.tsconf    = xt_w & (hoa == port_map_pkg::XT_TSCONF);
		video_wr.palsel    = xt_w & (hoa == port_map_pkg::XT_PALSEL);
		video_wr.tmpage    = xt_w & (hoa == port_map_pkg::XT_TMPAGE);
		video_wr.t0gpage   = xt_w & (hoa == port_map_pkg::XT_T0GPAGE);
		video_wr.t1gpage   = xt_w & (hoa == port_map_pkg::XT_T1GPAGE);
		video_wr.sgpage    = xt_w & (hoa == port_map_pkg::XT_SGPAGE);
		video_wr.hint_beg  = xt_w & (hoa == port_map_pkg::XT_HSINT);
		video_wr.vint_begl = xt_w & (hoa == port_map_pkg::XT_VSINTL);
		video_wr.vint_begh = xt_w & (hoa == port_map_pkg::XT_VSINTH);
	end

	always_comb
	begin
		dma_wr.saddrl = xt_w & (hoa == port_map_pkg::XT_DMASADDRL);
		dma_wr.saddrh = xt_w & (hoa == port_map_pkg::XT_DMASADDRH);
		dma_wr.saddrx = xt_w & (hoa == port_map_pkg::XT_DMASADDRX);
		dma_wr.daddrl = xt_w & (hoa == port_map_pkg::XT_DMADADDRL);
		dma_wr.daddrh = xt_w & (hoa == port_map_pkg::XT_DMADADDRH);
		dma_wr.daddrx = xt_w & (hoa == port_map_pkg::XT_DMADADDRX);
		dma_wr.len    = xt_w & (hoa == port_map_pkg::XT_DMALEN);
		dma_wr.ctrl   = xt_w & (hoa == port_map_pkg::XT_DMACTRL);
		dma_wr.num    = xt_w & (hoa == port_map_pkg::XT_DMANUM);
	end

	// sd card, config only outside dos, data reads start a transfer always
	assign sd_cfg_wr = sel.sdcfg & iowr_s & ~dos;
	assign sd_start  = (sel.sddat & iowr_s & ~dos) | (sel.sddat & iord_s);

	// read mux relies on at most one port select
	a_sel_onehot: assert #0 ($onehot0({sel.fe, sel.fd, sel.xt, sel.covox,
		sel.kjoy, sel.kmouse, sel.sdcfg, sel.sddat}));

endmodule

`default_nettype wire

//--- design/port_map_pkg.sv
// port map for the z80 i/o block: low-address port values, #AF register indices, select flags
`default_nettype none

package port_map_pkg;

	// ------------------------------------------------------------------------
	// low address byte of the ports kept in this block
	// ------------------------------------------------------------------------
	localparam logic [7:0] PORT_FE     = 8'hFE; // keys, tape, border, beeper
	localparam logic [7:0] PORT_FD     = 8'hFD; // 7ffd paging, sound chip with a15 set
	localparam logic [7:0] PORT_XT     = 8'hAF; // extended config, high byte is index
	localparam logic [7:0] PORT_COVOX  = 8'hFB;
	localparam logic [7:0] PORT_KJOY   = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam logic [7:0] PORT_SDCFG  = 8'h77;
	localparam logic [7:0] PORT_SDDAT  = 8'h57;

	// ------------------------------------------------------------------------
	// #nnAF register indices, nn = high address byte
	// ------------------------------------------------------------------------
	// video
	localparam logic [7:0] XT_VCONF     = 8'h00;
	localparam logic [7:0] XT_VPAGE     = 8'h01;
	localparam logic [7:0] XT_GXOFFSL   = 8'h02;
	localparam logic [7:0] XT_GXOFFSH   = 8'h03;
	localparam logic [7:0] XT_GYOFFSL   = 8'h04;
	localparam logic [7:0] XT_GYOFFSH   = 8'h05;
	localparam logic [7:0] XT_TSCONF    = 8'h06;
	localparam logic [7:0] XT_PALSEL    = 8'h07;
	localparam logic [7:0] XT_XBORDER   = 8'h0F;
	localparam logic [7:0] XT_T0XOFFSL  = 8'h40; // tile plane offsets, #40..#47
	localparam logic [7:0] XT_T0XOFFSH  = 8'h41;
	localparam logic [7:0] XT_T0YOFFSL  = 8'h42;
	localparam logic [7:0] XT_T0YOFFSH  = 8'h43;
	localparam logic [7:0] XT_T1XOFFSL  = 8'h44;
	localparam logic [7:0] XT_T1XOFFSH  = 8'h45;
	localparam logic [7:0] XT_T1YOFFSL  = 8'h46;
	localparam logic [7:0] XT_T1YOFFSH  = 8'h47;
	// memory and pages
	localparam logic [7:0] XT_RAMPAGE   = 8'h10; // base of four, #10..#13
	localparam logic [7:0] XT_FMADDR    = 8'h15;
	localparam logic [7:0] XT_TMPAGE    = 8'h16;
	localparam logic [7:0] XT_T0GPAGE   = 8'h17;
	localparam logic [7:0] XT_T1GPAGE   = 8'h18;
	localparam logic [7:0] XT_SGPAGE    = 8'h19;
	// dma setup
	localparam logic [7:0] XT_DMASADDRL = 8'h1A;
	localparam logic [7:0] XT_DMASADDRH = 8'h1B;
	localparam logic [7:0] XT_DMASADDRX = 8'h1C;
	localparam logic [7:0] XT_DMADADDRL = 8'h1D;
	localparam logic [7:0] XT_DMADADDRH = 8'h1E;
	localparam logic [7:0] XT_DMADADDRX = 8'h1F;
	localparam logic [7:0] XT_DMALEN    = 8'h26;
	localparam logic [7:0] XT_DMACTRL   = 8'h27;
	localparam logic [7:0] XT_DMANUM    = 8'h28;
	// system
	localparam logic [7:0] XT_SYSCONF   = 8'h20;
	localparam logic [7:0] XT_MEMCONF   = 8'h21;
	localparam logic [7:0] XT_HSINT     = 8'h22;
	localparam logic [7:0] XT_VSINTL    = 8'h23;
	localparam logic [7:0] XT_VSINTH    = 8'h24;
	localparam logic [7:0] XT_FDDVIRT   = 8'h29;
	localparam logic [7:0] XT_INTMASK   = 8'h2A;
	localparam logic [7:0] XT_CACHECONF = 8'h2B;
	// read side, shares numbers with write registers
	localparam logic [7:0] XT_XSTAT     = 8'h00;
	localparam logic [7:0] XT_DMASTAT   = 8'h27;

	// one flag per kept port, raw low-byte compare, no dos gating
	typedef struct packed {
		logic fe;
		logic fd;
		logic xt;
		logic covox;
		logic kjoy;
		logic kmouse;
		logic sdcfg;
		logic sddat;
		logic ay;     // sound chip, fd with a15 high
	} port_sel_t;

endpackage

`default_nettype wire

//--- design/port_read_mux.sv
// port read path: data multiplexer for cpu reads and the power-up status flag
`default_nettype none

module port_read_mux
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire port_map_pkg::port_sel_t sel,
	input  wire [7:0]                    a_hi,
	input  wire                          iord_s,
	input  wire [7:0]                    page2,
	input  wire [7:0]                    page3,
	input  wire                          dma_act,
	input  wire                          tape_read,
	input  wire [4:0]                    keys_in,
	input  wire [4:0]                    kj_in,
	input  wire [7:0]                    mus_in,
	input  wire [7:0]                    sd_dataout,
	output logic [7:0]                   dout
);

	logic       pwr_up;   // set by reset, cleared by first status read
	logic [7:0] xt_dout;

	always_ff @(posedge clk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (iord_s && sel.xt && (a_hi == port_map_pkg::XT_XSTAT))
			pwr_up <= 1'b0;  // same-cycle read still sees 1
	end

	// ------------------------------------------------------------------------
	// #nnAF readback
	// ------------------------------------------------------------------------
	always_comb
	begin
		case (a_hi)
			port_map_pkg::XT_XSTAT:          xt_dout = {1'b0, pwr_up, 6'b000011};
			port_map_pkg::XT_DMASTAT:        xt_dout = {dma_act, 7'b0000000};
			port_map_pkg::XT_RAMPAGE + 8'd2: xt_dout = page2;
			port_map_pkg::XT_RAMPAGE + 8'd3: xt_dout = page3;
			default:                         xt_dout = 8'hFF;
		endcase
	end

	// ------------------------------------------------------------------------
	// port mux
	// ------------------------------------------------------------------------
	always_comb
	begin
		if (sel.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.xt)
			dout = xt_dout;
		else if (sel.kjoy)
			dout = {3'b000, kj_in};
		else if (sel.kmouse)
			dout = mus_in;
		else if (sel.sdcfg)
			dout = 8'h00;       // card present, not write protected
		else if (sel.sddat)
			dout = sd_dataout;
		else
			dout = 8'hFF;       // open bus
	end

	// the flag only comes back through reset
	a_pwr_up_rise: assert property (@(posedge clk) $rose(pwr_up) |-> $past(rst));

endmodule

`default_nettype wire

//--- design/port_regs.sv
// port registers: #AF configuration set, 7ffd paging with lock modes, sd chip select
`default_nettype none

module port_regs
(
	input  wire                     clk,
	input  wire                     rst,
	input  wire [7:0]               din,
	input  wire                     opfetch,
	input  wire                     wr,
	input  wire [7:0]               a_hi,      // selects one of four pages
	input  wire zcfg_pkg::xt_wr_t   xt_wr,
	input  wire                     sd_cfg_wr,
	output zcfg_pkg::cfg_regs_t     cfg,
	output logic                    lock48,
	output logic                    sdcs_n,
	output logic [7:0]              sd_datain
);

	logic       mode2;       // lock from opcode fetch
	logic       mode3;       // 1024k, no 128 lock
	logic       lock128;
	logic       m1_lock128;
	logic [7:0] page3_nxt;   // page 3 value for a 7ffd write

	// ------------------------------------------------------------------------
	// lock mode and 7ffd page mapping
	// ------------------------------------------------------------------------
	assign mode2 = (cfg.memconf[7:6] == zcfg_pkg::LOCK_MODE2);
	assign mode3 = (cfg.memconf[7:6] == zcfg_pkg::LOCK_MODE3);

	always_comb
	begin
		if (mode3)
			lock128 = 1'b0;
		else if (mode2)
			lock128 = m1_lock128;
		else
			lock128 = cfg.memconf[6];   // modes 0 and 1
	end

	always_comb
	begin
		if (mode3)
			page3_nxt = {2'b00, din[5], din[7:6], din[2:0]};  // pentagon 1024 order
		else
			page3_nxt = {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
	end

	// opcode byte seen by the cpu, locked when bits 7 and 6 match
	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= ~(din[7] ^ din[6]);
	end

	// ------------------------------------------------------------------------
	// configuration registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg.sysconf   <= zcfg_pkg::SYSCONF_RST;
			cfg.memconf   <= zcfg_pkg::MEMCONF_RST;
			cfg.cacheconf <= zcfg_pkg::CACHECONF_RST;
			cfg.fmaddr    <= zcfg_pkg::FMADDR_RST;
			cfg.intmask   <= zcfg_pkg::INTMASK_RST;
			cfg.fddvirt   <= zcfg_pkg::FDDVIRT_RST;
			cfg.xt_page   <= zcfg_pkg::BANK_RST;
		end
		else if (xt_wr.p7ffd)
		begin
			cfg.memconf[0] <= din[4];        // rom 128/48 select
			cfg.xt_page[3] <= page3_nxt;
		end
		else
		begin
			if (xt_wr.rampage)
				cfg.xt_page[a_hi[1:0]] <= din;
			if (xt_wr.fmaddr)
				cfg.fmaddr <= din[4:0];
			if (xt_wr.sysconf)
			begin
				cfg.sysconf   <= din;
				cfg.cacheconf <= {4{din[2]}}; // cache follows turbo bit
			end
			if (xt_wr.cacheconf)
				cfg.cacheconf <= din[3:0];
			if (xt_wr.memconf)
				cfg.memconf <= din;
			if (xt_wr.fddvirt)
				cfg.fddvirt <= din[3:0];
			if (xt_wr.intmask)
				cfg.intmask <= din;
		end
	end

	// ------------------------------------------------------------------------
	// lock48 and sd card
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (xt_wr.p7ffd && !mode3)
			lock48 <= din[5];   // once set only reset reopens 7ffd
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;     // card deselected
		else if (sd_cfg_wr)
			sdcs_n <= din[1];
	end

	assign sd_datain = wr ? din : 8'hFF;  // spi sends ones on reads

	// decoder blocks 7ffd while lock48 is set, so lock48 must hold
	a_lock48_hold: assert property (@(posedge clk) disable iff (rst)
		(!xt_wr.p7ffd || lock48) |=> $stable(lock48));

endmodule

`default_nettype wire

//--- design/zcfg_pkg.sv
// configuration types for the i/o block: reset values, lock modes, register and strobe structs
`default_nettype none

package zcfg_pkg;

	// ------------------------------------------------------------------------
	// reset values
	// ------------------------------------------------------------------------
	localparam logic [7:0]  SYSCONF_RST   = 8'h01; // turbo 7 MHz
	localparam logic [7:0]  MEMCONF_RST   = 8'h04; // w0 map off, lock mode 0
	localparam logic [3:0]  CACHECONF_RST = 4'h0;  // cache disabled
	localparam logic [7:0]  INTMASK_RST   = 8'h01; // frame int only
	localparam logic [3:0]  FDDVIRT_RST   = 4'h1;  // drive a virtual
	localparam logic [4:0]  FMADDR_RST    = 5'h00;
	// page 3 in the top byte, page 0 in the low byte
	localparam logic [31:0] BANK_RST      = {8'h00, 8'h02, 8'h05, 8'h00};

	// memconf[7:6] lock modes, 0 and 1 use memconf[6] directly
	localparam logic [1:0]  LOCK_MODE2    = 2'b10; // lock from last opcode fetch
	localparam logic [1:0]  LOCK_MODE3    = 2'b11; // pentagon 1024, no lock

	// ------------------------------------------------------------------------
	// register state seen by the rest of the machine
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [7:0]      sysconf;
		logic [7:0]      memconf;
		logic [3:0]      cacheconf;
		logic [4:0]      fmaddr;
		logic [7:0]      intmask;
		logic [3:0]      fddvirt;
		logic [3:0][7:0] xt_page;   // cpu windows 0..3
	} cfg_regs_t;

	// write enables into port_regs, already qualified by iowr_s
	typedef struct packed {
		logic rampage;
		logic fmaddr;
		logic sysconf;
		logic memconf;
		logic cacheconf;
		logic fddvirt;
		logic intmask;
		logic p7ffd;
	} xt_wr_t;

	// video and interrupt register strobes
	typedef struct packed {
		logic zborder;
		logic border;
		logic zvpage;
		logic vpage;
		logic vconf;
		logic gx_offsl;
		logic gx_offsh;
		logic gy_offsl;
		logic gy_offsh;
		logic t0x_offsl;
		logic t0x_offsh;
		logic t0y_offsl;
		logic t0y_offsh;
		logic t1x_offsl;
		logic t1x_offsh;
		logic t1y_offsl;
		logic t1y_offsh;
		logic tsconf;
		logic palsel;
		logic tmpage;
		logic t0gpage;
		logic t1gpage;
		logic sgpage;
		logic hint_beg;
		logic vint_begl;
		logic vint_begh;
	} video_wr_t;

	// dma register strobes
	typedef struct packed {
		logic saddrl;
		logic saddrh;
		logic saddrx;
		logic daddrl;
		logic daddrh;
		logic daddrx;
		logic len;
		logic ctrl;
		logic num;
	} dma_wr_t;

endpackage

`default_nettype wire

//--- design/zports_top.sv
// i/o port block top: joins the decoder, configuration registers and read path
`default_nettype none

module zports_top
(
	input  wire                     clk,
	input  wire                     rst,
	// cpu bus
	input  wire [15:0]              a,
	input  wire [7:0]               din,
	input  wire                     iord,
	input  wire                     iord_s,
	input  wire                     iowr_s,
	input  wire                     wr,
	input  wire                     opfetch,
	input  wire                     dos,
	output logic [7:0]              dout,
	output logic                    dataout,
	output logic                    porthit,
	output logic                    external_port,
	// read sources
	input  wire                     dma_act,
	input  wire                     tape_read,
	input  wire [4:0]               keys_in,
	input  wire [4:0]               kj_in,
	input  wire [7:0]               mus_in,
	input  wire [7:0]               sd_dataout,
	// configuration and strobes
	output zcfg_pkg::cfg_regs_t     cfg,
	output zcfg_pkg::video_wr_t     video_wr,
	output zcfg_pkg::dma_wr_t       dma_wr,
	output logic                    beeper_wr,
	output logic                    covox_wr,
	// sd card spi
	output logic                    sdcs_n,
	output logic                    sd_start,
	output logic [7:0]              sd_datain
);

	port_map_pkg::port_sel_t sel;
	zcfg_pkg::xt_wr_t        xt_wr;
	logic                    lock48;
	logic                    sd_cfg_wr;

	// ------------------------------------------------------------------------
	// decode, registers, read path
	// ------------------------------------------------------------------------
	port_decode u_decode
	(
		.a             (a),
		.iowr_s        (iowr_s),
		.iord_s        (iord_s),
		.iord          (iord),
		.dos           (dos),
		.lock48        (lock48),
		.sel           (sel),
		.xt_wr         (xt_wr),
		.video_wr      (video_wr),
		.dma_wr        (dma_wr),
		.beeper_wr     (beeper_wr),
		.covox_wr      (covox_wr),
		.sd_cfg_wr     (sd_cfg_wr),
		.sd_start      (sd_start),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout)
	);

	port_regs u_regs
	(
		.clk       (clk),
		.rst       (rst),
		.din       (din),
		.opfetch   (opfetch),
		.wr        (wr),
		.a_hi      (a[15:8]),
		.xt_wr     (xt_wr),
		.sd_cfg_wr (sd_cfg_wr),
		.cfg       (cfg),
		.lock48    (lock48),
		.sdcs_n    (sdcs_n),
		.sd_datain (sd_datain)
	);

	port_read_mux u_read
	(
		.clk        (clk),
		.rst        (rst),
		.sel        (sel),
		.a_hi       (a[15:8]),
		.iord_s     (iord_s),
		.page2      (cfg.xt_page[2]),   // only pages 2 and 3 read back
		.page3      (cfg.xt_page[3]),
		.dma_act    (dma_act),
		.tape_read  (tape_read),
		.keys_in    (keys_in),
		.kj_in      (kj_in),
		.mus_in     (mus_in),
		.sd_dataout (sd_dataout),
		.dout       (dout)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the i/o port block testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_zports -o tb_zports_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_zports_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

//--- sources.f
+incdir+testbench
design/port_map_pkg.sv
design/zcfg_pkg.sv
design/port_decode.sv
design/port_regs.sv
design/port_read_mux.sv
design/zports_top.sv
testbench/tb_zports.sv

//--- testbench/zports_model.svh
// reference model for the i/o port block: shadow registers and expected decode values
`ifndef ZPORTS_MODEL_SVH
`define ZPORTS_MODEL_SVH

zcfg_pkg::cfg_regs_t m_cfg;
logic                m_lock48;
logic                m_m1_lock128;  // lock taken from last opcode byte
logic                m_pwr_up;
logic                m_sdcs_n;

task automatic model_reset();
	m_cfg.sysconf   = 8'h01;
	m_cfg.memconf   = 8'h04;
	m_cfg.cacheconf = 4'h0;
	m_cfg.fmaddr    = 5'h00;
	m_cfg.intmask   = 8'h01;
	m_cfg.fddvirt   = 4'h1;
	m_cfg.xt_page   = {8'h00, 8'h02, 8'h05, 8'h00};  // page 3 down to page 0
	m_lock48        = 1'b0;
	m_m1_lock128    = 1'b0;
	m_pwr_up        = 1'b1;
	m_sdcs_n        = 1'b1;
endtask

task automatic model_opfetch(input logic [7:0] d);
	m_m1_lock128 = (d[7] == d[6]);  // locked when top bits match
endtask

// state after an iowr_s cycle
task automatic model_write(input logic [15:0] ad, input logic [7:0] d, input logic ds);
	logic [7:0] lo;
	logic [7:0] hi;
	logic [1:0] mode;
	logic       lk;
	lo = ad[7:0];
	hi = ad[15:8];
	mode = m_cfg.memconf[7:6];
	if (lo == 8'hAF)
	begin
		case (hi)
			8'h10, 8'h11, 8'h12, 8'h13: m_cfg.xt_page[hi[1:0]] = d;
			8'h15: m_cfg.fmaddr = d[4:0];
			8'h20:
			begin
				m_cfg.sysconf   = d;
				m_cfg.cacheconf = {4{d[2]}};  // copy of turbo bit
			end
			8'h21: m_cfg.memconf = d;
			8'h29: m_cfg.fddvirt = d[3:0];
			8'h2A: m_cfg.intmask = d;
			8'h2B: m_cfg.cacheconf = d[3:0];
			default: ;
		endcase
	end
	if (lo == 8'hFD && !ad[15] && !m_lock48)
	begin
		if (mode == 2'b11)
			m_cfg.xt_page[3] = {2'b00, d[5], d[7:6], d[2:0]};
		else
		begin
			lk = (mode == 2'b10) ? m_m1_lock128 : m_cfg.memconf[6];
			m_cfg.xt_page[3] = {3'b000, lk ? 2'b00 : d[7:6], d[2:0]};
			m_lock48 = d[5];
		end
		m_cfg.memconf[0] = d[4];
	end
	if (lo == 8'h77 && !ds)
		m_sdcs_n = d[1];
endtask

task automatic model_read(input logic [15:0] ad);
	if (ad == 16'h00AF)
		m_pwr_up = 1'b0;  // first status read clears it
endtask

function automatic logic exp_porthit(input logic [15:0] ad, input logic ds);
	logic [7:0] lo;
	lo = ad[7:0];
	exp_porthit = (lo == 8'hFE) || (lo == 8'hAF) || (lo == 8'hFD) || (lo == 8'hFB)
		|| (lo == 8'hDF) || (!ds && (lo == 8'h1F || lo == 8'h77 || lo == 8'h57));
endfunction

`endif

//--- testbench/tb_zports.sv
// testbench for the i/o port block: random port traffic checked against a shadow model
`default_nettype none

module tb_zports;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 5000;  // about 3000 cycles of tests

	logic clk = 1'b0;
	logic rst;
	logic [15:0] a;
	logic [7:0] din, dout, mus_in, sd_dataout, sd_datain;
	logic iord, iord_s, iowr_s, wr, opfetch, dos, dma_act, tape_read;
	logic [4:0] keys_in, kj_in;
	logic dataout, porthit, external_port, beeper_wr, covox_wr, sdcs_n, sd_start;
	zcfg_pkg::cfg_regs_t cfg;
	zcfg_pkg::video_wr_t video_wr;
	zcfg_pkg::dma_wr_t   dma_wr;

	integer seed = 32'h6dabe8c5;
	int     errors = 0;
	int     cycles = 0;
	int     t0;

	`include "zports_model.svh"

	zports_top UUT (.clk(clk), .rst(rst), .a(a), .din(din), .iord(iord), .iord_s(iord_s),
		.iowr_s(iowr_s), .wr(wr), .opfetch(opfetch), .dos(dos), .dout(dout),
		.dataout(dataout), .porthit(porthit), .external_port(external_port),
		.dma_act(dma_act), .tape_read(tape_read), .keys_in(keys_in), .kj_in(kj_in),
		.mus_in(mus_in), .sd_dataout(sd_dataout), .cfg(cfg), .video_wr(video_wr),
		.dma_wr(dma_wr), .beeper_wr(beeper_wr), .covox_wr(covox_wr), .sdcs_n(sdcs_n),
		.sd_start(sd_start), .sd_datain(sd_datain));

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic test_done(input string name);
		$display("test %s: %s (%0d errors)", name, (errors == t0) ? "ok" : "FAILED",
			errors - t0);
		t0 = errors;
	endtask

	// ------------------------------------------------------------------------
	// bus cycles, all driven on the falling edge
	// ------------------------------------------------------------------------
	task automatic drive(input logic [15:0] ad, input logic [7:0] d, input logic wrs,
		input logic rds, input logic rdl, input logic ds);
		@(negedge clk);
		a = ad;
		din = d;
		iowr_s = wrs;
		iord_s = rds;
		iord = rdl;
		dos = ds;
	endtask

	task automatic idle();
		@(negedge clk);
		iowr_s = 1'b0;
		iord_s = 1'b0;
		iord = 1'b0;
		opfetch = 1'b0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		model_reset();
	endtask

	// write one port, then compare registers one cycle later
	task automatic io_write(input logic [15:0] ad, input logic [7:0] d, input logic ds);
		drive(ad, d, 1'b1, 1'b0, 1'b0, ds);
		model_write(ad, d, ds);
		idle();
		check("cfg", cfg, m_cfg);
		check("sdcs_n", sdcs_n, m_sdcs_n);
	endtask

	task automatic read_check(input logic [15:0] ad, input logic rds);
		drive(ad, 8'h00, 1'b0, rds, 1'b1, 1'b0);
		#1;
		check("dout", dout, exp_dout(ad));
		if (rds)
			model_read(ad);
		idle();
	endtask

	task automatic opfetch_cycle(input logic [7:0] d);
		@(negedge clk);
		opfetch = 1'b1;
		din = d;
		model_opfetch(d);
		idle();
	endtask

	task automatic set_mode(input logic [1:0] mode);
		io_write(16'h21AF, {mode, 6'($random(seed))}, 1'b0);  // memconf
	endtask

	function automatic logic [7:0] exp_dout(input logic [15:0] ad);
		case (ad[7:0])
			8'hFE: exp_dout = {1'b1, tape_read, 1'b0, keys_in};
			8'hAF:
				case (ad[15:8])
					8'h00: exp_dout = {1'b0, m_pwr_up, 6'b000011};
					8'h27: exp_dout = {dma_act, 7'b0};
					8'h12: exp_dout = m_cfg.xt_page[2];
					8'h13: exp_dout = m_cfg.xt_page[3];
					default: exp_dout = 8'hFF;
				endcase
			8'h1F: exp_dout = {3'b000, kj_in};
			8'hDF: exp_dout = mus_in;
			8'h77: exp_dout = 8'h00;
			8'h57: exp_dout = sd_dataout;
			default: exp_dout = 8'hFF;  // nobody answers
		endcase
	endfunction

	function automatic zcfg_pkg::video_wr_t exp_video(input logic [15:0] ad, input logic wrs,
		input logic l48);
		zcfg_pkg::video_wr_t v;
		logic x;
		logic [7:0] h;
		x = wrs && (ad[7:0] == 8'hAF);
		h = ad[15:8];
		v = '0;
		v.zborder = wrs && (ad[7:0] == 8'hFE);
		v.zvpage = wrs && (ad[7:0] == 8'hFD) && !ad[15] && !l48;
		v.border = x && h == 8'h0F;
		v.vpage = x && h == 8'h01;
		v.vconf = x && h == 8'h00;
		{v.gx_offsl, v.gx_offsh, v.gy_offsl, v.gy_offsh} =
			{x && h == 8'h02, x && h == 8'h03, x && h == 8'h04, x && h == 8'h05};
		{v.t0x_offsl, v.t0x_offsh, v.t0y_offsl, v.t0y_offsh} =
			{x && h == 8'h40, x && h == 8'h41, x && h == 8'h42, x && h == 8'h43};
		{v.t1x_offsl, v.t1x_offsh, v.t1y_offsl, v.t1y_offsh} =
			{x && h == 8'h44, x && h == 8'h45, x && h == 8'h46, x && h == 8'h47};
		{v.tsconf, v.palsel} = {x && h == 8'h06, x && h == 8'h07};
		{v.tmpage, v.t0gpage, v.t1gpage, v.sgpage} =
			{x && h == 8'h16, x && h == 8'h17, x && h == 8'h18, x && h == 8'h19};
		{v.hint_beg, v.vint_begl, v.vint_begh} =
			{x && h == 8'h22, x && h == 8'h23, x && h == 8'h24};
		exp_video = v;
	endfunction

	function automatic logic [8:0] exp_dma(input logic [15:0] ad, input logic wrs);
		logic [7:0] h;
		logic x;
		h = ad[15:8];
		x = wrs && (ad[7:0] == 8'hAF);
		exp_dma = {x && h == 8'h1A, x && h == 8'h1B, x && h == 8'h1C, x && h == 8'h1D,
			x && h == 8'h1E, x && h == 8'h1F, x && h == 8'h26, x && h == 8'h27, x && h == 8'h28};
	endfunction

	function automatic logic [7:0] pick_port(input int unsigned i);
		logic [7:0] ports [8];
		ports = '{8'hFE, 8'hFD, 8'hAF, 8'hFB, 8'h1F, 8'hDF, 8'h77, 8'h57};
		pick_port = ports[i % 8];
	endfunction

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		logic [15:0] ad;
		logic [7:0]  d, idx, lo;
		logic        wrs, rds, rdl, ds;
		logic [7:0]  xt_idx [10];
		xt_idx = '{8'h10, 8'h11, 8'h12, 8'h13, 8'h15, 8'h20, 8'h21, 8'h29, 8'h2A, 8'h2B};
		rst = 1'b1;
		a = '0;
		din = '0;
		iord = 0;
		iord_s = 0;
		iowr_s = 0;
		wr = 0;
		opfetch = 0;
		dos = 0;
		dma_act = 0;
		tape_read = 0;
		keys_in = '0;
		kj_in = '0;
		mus_in = '0;
		sd_dataout = '0;
		t0 = 0;
		apply_reset();

		// 1: reset state and power-up flag
		@(negedge clk);
		check("cfg", cfg, m_cfg);
		check("sdcs_n", sdcs_n, 1'b1);
		read_check(16'h00AF, 1'b1);   // flag still 1
		read_check(16'h00AF, 1'b1);   // now cleared
		test_done("reset");

		// 2: extended register writes and page readback
		repeat (150)
		begin
			idx = xt_idx[$unsigned($random(seed)) % 10];
			io_write({idx, 8'hAF}, 8'($random(seed)), 1'($random(seed)));
			read_check(16'h12AF, 1'b0);
			read_check(16'h13AF, 1'b0);
		end
		test_done("xt_regs");

		// 3: 7ffd under the four lock modes
		for (int mode = 0; mode < 4; mode++)
		begin
			apply_reset();
			set_mode(2'(mode));
			repeat (80)
			begin
				opfetch_cycle(8'($random(seed)));
				io_write({1'b0, 7'($random(seed)), 8'hFD}, 8'($random(seed)), 1'b0);
				if (m_lock48 && ($unsigned($random(seed)) % 4 == 0))
				begin
					apply_reset();   // only reset reopens 7ffd
					set_mode(2'(mode));
				end
			end
		end
		test_done("p7ffd");

		// 4: decode and write strobes
		repeat (300)
		begin
			case ($unsigned($random(seed)) % 4)
				0: ad = {8'($random(seed)), pick_port($unsigned($random(seed)))};
				1: ad = {8'($unsigned($random(seed)) % 8'h50), 8'hAF};
				2: ad = {8'($random(seed)), 8'hFD};
				default: ad = 16'($random(seed));
			endcase
			d = 8'($random(seed));
			{wrs, rds, rdl, ds} = 4'($random(seed));
			drive(ad, d, wrs, rds, rdl, ds);
			#1;
			check("porthit", porthit, exp_porthit(ad, ds));
			check("external_port", external_port, ad[7:0] == 8'hFD && ad[15]);
			check("dataout", dataout, exp_porthit(ad, ds) && rdl && !(ad[7:0] == 8'hFD && ad[15]));
			check("video_wr", video_wr, exp_video(ad, wrs, m_lock48));
			check("dma_wr", dma_wr, exp_dma(ad, wrs));
			check("beeper_wr", beeper_wr, wrs && ad[7:0] == 8'hFE);
			check("covox_wr", covox_wr, wrs && ad[7:0] == 8'hFB);
			check("sd_start", sd_start, ad[7:0] == 8'h57 && ((wrs && !ds) || rds));
			if (wrs)
				model_write(ad, d, ds);
			if (rds)
				model_read(ad);
			idle();
			check("cfg", cfg, m_cfg);
		end
		test_done("decode");

		// 5: read sources
		repeat (120)
		begin
			dma_act = 1'($random(seed));
			tape_read = 1'($random(seed));
			keys_in = 5'($random(seed));
			kj_in = 5'($random(seed));
			mus_in = 8'($random(seed));
			sd_dataout = 8'($random(seed));
			case ($unsigned($random(seed)) % 3)
				0: lo = pick_port($unsigned($random(seed)));
				1: lo = 8'hAF;
				default: lo = 8'($random(seed));  // mostly unknown ports
			endcase
			idx = ($unsigned($random(seed)) % 2) ? 8'h27 : 8'($random(seed));
			read_check({lo == 8'hAF ? idx : 8'($random(seed)), lo}, 1'b0);
		end
		test_done("read_mux");

		// 6: sd chip select and data out
		repeat (60)
		begin
			io_write({8'($random(seed)), 8'h77}, 8'($random(seed)), 1'($random(seed)));
			@(negedge clk);
			wr = 1'($random(seed));
			d = 8'($random(seed));
			din = d;
			#1;
			if (wr)
				check("sd_datain", sd_datain, d);
			else
				check("sd_datain", sd_datain, 8'hFF);  // ones shifted out on reads
		end
		test_done("sd_card");

		$display("done: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
